// File: Makefile
# Verilator build and run of the app_top testbench

TOP       ?= tb_app_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "test: failure in $(LOG)"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "test: no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: app_top.sv
////////////////////////////////////////////////////////////////////////////
// Board glue top on igp_clk: registers, IQ join, reference, rate meter
// and user GPIO; no back-pressure on any path
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module app_top (
    input  logic                            igp_clk,
    input  logic                            igp_rst,
    input  igp_pkg::gpo_wr_t                gpo_wr_i,
    input  logic [igp_pkg::ADC_W-1:0]       rxd_data_i,
    input  logic                            rxd_iqsel_i,
    input  logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_in_i,
    output igp_pkg::board_ctrl_t            board_ctrl_o,
    output igp_pkg::iq_sample_t             sample_o,
    output logic                            sample_valid_o,
    output logic [igp_pkg::CNT_W-1:0]       meas_count_o,
    output logic                            meas_valid_o,
    output logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_out_o,
    output logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_oe_o
);

    logic               rx_stream_en;
    igp_pkg::ref_sel_e  ref_sel;
    igp_pkg::gpio_cfg_t gpio_cfg;
    logic               pps_pin;
    logic               ref_level;

    gpo_regs gpo_regs_i (
        .igp_clk        (igp_clk),
        .igp_rst        (igp_rst),
        .gpo_wr_i       (gpo_wr_i),
        .board_ctrl_o   (board_ctrl_o),
        .rx_stream_en_o (rx_stream_en),
        .ref_sel_o      (ref_sel),
        .gpio_cfg_o     (gpio_cfg)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Sample path and rate measurement
    iq_demux iq_demux_i (
        .igp_clk        (igp_clk),
        .igp_rst        (igp_rst),
        .stream_en_i    (rx_stream_en),
        .rxd_data_i     (rxd_data_i),
        .rxd_iqsel_i    (rxd_iqsel_i),
        .sample_o       (sample_o),
        .sample_valid_o (sample_valid_o)
    );

    ref_tick_gen ref_tick_gen_i (
        .igp_clk   (igp_clk),
        .igp_rst   (igp_rst),
        .ref_sel_i (ref_sel),
        .pps_i     (pps_pin),
        .ref_o     (ref_level)
    );

    rate_meter rate_meter_i (
        .igp_clk       (igp_clk),
        .igp_rst       (igp_rst),
        .ref_i         (ref_level),
        .event_i       (sample_valid_o),
        .count_o       (meas_count_o),
        .count_valid_o (meas_valid_o)
    );

    // LED register stands in for tx activity
    pin_mux pin_mux_i (
        .gpio_cfg_i      (gpio_cfg),
        .rx_active_i     (rx_stream_en),
        .tx_active_i     (board_ctrl_o.led),
        .user_gpio_in_i  (user_gpio_in_i),
        .user_gpio_out_o (user_gpio_out_o),
        .user_gpio_oe_o  (user_gpio_oe_o),
        .pps_o           (pps_pin)
    );

endmodule

`default_nettype wire

// File: compile.f
igp_pkg.sv
gpo_regs.sv
iq_demux.sv
ref_tick_gen.sv
rate_meter.sv
pin_mux.sv
app_top.sv
tb_clk_gen.sv
tb_app_top.sv

// File: gpo_regs.sv
////////////////////////////////////////////////////////////////////////////
// Byte-wide output registers, written by a one-cycle strobe
// Writes at or above IGPO_COUNT are dropped; decoded fields follow a write
// by one cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gpo_regs (
    input  logic                 igp_clk,
    input  logic                 igp_rst,
    input  igp_pkg::gpo_wr_t     gpo_wr_i,
    output igp_pkg::board_ctrl_t board_ctrl_o,
    output logic                 rx_stream_en_o,
    output igp_pkg::ref_sel_e    ref_sel_o,
    output igp_pkg::gpio_cfg_t   gpio_cfg_o
);

    logic [7:0] regs [igp_pkg::IGPO_COUNT];

    always_ff @(posedge igp_clk) begin
        if (igp_rst) begin
            for (int k = 0; k < igp_pkg::IGPO_COUNT; k++) begin
                regs[k] <= 8'h00;
            end
        end else if (gpo_wr_i.valid && (gpo_wr_i.addr < igp_pkg::IGPO_COUNT)) begin
            regs[gpo_wr_i.addr] <= gpo_wr_i.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register map decode
    always_comb begin
        board_ctrl_o.lms_rst_n  = regs[igp_pkg::LMS_RST][0];
        board_ctrl_o.rxmix_en   = regs[igp_pkg::RXMIX_EN][0];
        board_ctrl_o.txsw       = regs[igp_pkg::TXSW][0];
        board_ctrl_o.rxsw       = regs[igp_pkg::RXSW][0];
        board_ctrl_o.dcen       = regs[igp_pkg::BOOSTER][0];
        board_ctrl_o.led        = regs[igp_pkg::LED][0];
        board_ctrl_o.enable_osc = regs[igp_pkg::ENABLE_OSC][0];
    end

    assign rx_stream_en_o = regs[igp_pkg::STREAM][0];
    assign ref_sel_o      = igp_pkg::ref_sel_e'(regs[igp_pkg::CLKMEAS][1:0]);

    // 15 pins split over two bytes, top bit of the high byte unused
    assign gpio_cfg_o.altf     = regs[igp_pkg::GPIO_ALTF];
    assign gpio_cfg_o.data_out = {regs[igp_pkg::GPIO_OUT_HI][6:0], regs[igp_pkg::GPIO_OUT_LO]};
    assign gpio_cfg_o.data_oe  = {regs[igp_pkg::GPIO_OE_HI][6:0], regs[igp_pkg::GPIO_OE_LO]};

    // Host must stay inside the register map
    a_wr_addr_in_map: assert property (@(posedge igp_clk) disable iff (igp_rst)
        gpo_wr_i.valid |-> (gpo_wr_i.addr < igp_pkg::IGPO_COUNT));

endmodule

`default_nettype wire

// File: igp_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Register map and shared types of the board glue, single igp_clk domain
// REF_HALF_PERIOD is scaled down for simulation; the board runs 62.5e6
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package igp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register bank
    localparam int IGPO_COUNT = 18;
    localparam int GPO_ADDR_W = 5;

    typedef enum logic [GPO_ADDR_W-1:0] {
        LMS_RST     = 5'd0,
        RXMIX_EN    = 5'd1,
        TXSW        = 5'd2,
        RXSW        = 5'd3,
        BOOSTER     = 5'd7,
        LED         = 5'd8,
        STREAM      = 5'd10,
        GPIO_ALTF   = 5'd11,
        GPIO_OUT_LO = 5'd12,
        GPIO_OUT_HI = 5'd13,
        GPIO_OE_LO  = 5'd14,
        GPIO_OE_HI  = 5'd15,
        CLKMEAS     = 5'd16,
        ENABLE_OSC  = 5'd17
    } gpo_reg_e;

    // Single-cycle write strobe, no back-pressure
    typedef struct packed {
        logic                  valid;
        logic [GPO_ADDR_W-1:0] addr;
        logic [7:0]            data;
    } gpo_wr_t;

    typedef struct packed {
        logic lms_rst_n;
        logic rxmix_en;
        logic txsw;
        logic rxsw;
        logic dcen;
        logic led;
        logic enable_osc;
    } board_ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // User GPIO
    localparam int USER_GPIO_W   = 18;
    localparam int EGPIO_W       = 15;
    localparam int GPIO_FUNC_PPS = 2;
    localparam int GPIO_FUNC_LED = 0;

    typedef struct packed {
        logic [7:0]         altf;
        logic [EGPIO_W-1:0] data_out;
        logic [EGPIO_W-1:0] data_oe;
    } gpio_cfg_t;

    ////////////////////////////////////////////////////////////////////////////
    // Samples and measurement
    localparam int ADC_W = 12;

    // i in the upper half, as it arrives with iqsel high
    typedef struct packed {
        logic [ADC_W-1:0] i;
        logic [ADC_W-1:0] q;
    } iq_sample_t;

    // Code 3 has no name and behaves as off
    typedef enum logic [1:0] {
        REF_PPS      = 2'd0,
        REF_INTERNAL = 2'd1,
        REF_OFF      = 2'd2
    } ref_sel_e;

    localparam int REF_HALF_PERIOD = 50;
    localparam int REF_DIV_W       = $clog2(REF_HALF_PERIOD);
    localparam int CNT_W           = 28;

endpackage

`default_nettype wire

// File: iq_demux.sv
////////////////////////////////////////////////////////////////////////////
// Joins interleaved 12-bit halves into IQ pairs, q first then i
// Expects iqsel to alternate; stream disable holds the valid in reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module iq_demux (
    input  logic                      igp_clk,
    input  logic                      igp_rst,
    input  logic                      stream_en_i,
    input  logic [igp_pkg::ADC_W-1:0] rxd_data_i,
    input  logic                      rxd_iqsel_i,
    output igp_pkg::iq_sample_t       sample_o,
    output logic                      sample_valid_o
);

    // Valid follows the i half by one cycle
    always_ff @(posedge igp_clk) begin
        if (igp_rst || !stream_en_i) begin
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= rxd_iqsel_i;
        end
    end

    // Payload halves
    always_ff @(posedge igp_clk) begin
        if (stream_en_i) begin
            if (rxd_iqsel_i) begin
                sample_o.i <= rxd_data_i;
            end else begin
                sample_o.q <= rxd_data_i;
            end
        end
    end

    a_valid_single: assert property (@(posedge igp_clk) disable iff (igp_rst)
        sample_valid_o |=> !sample_valid_o);

endmodule

`default_nettype wire

// File: pin_mux.sv
////////////////////////////////////////////////////////////////////////////
// User GPIO routing: pins 14:0 plain, 15 unused, 17:16 status LEDs
// PPS on pin 2 releases that pin's output enable
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pin_mux (
    input  igp_pkg::gpio_cfg_t              gpio_cfg_i,
    input  logic                            rx_active_i,
    input  logic                            tx_active_i,
    input  logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_in_i,
    output logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_out_o,
    output logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_oe_o,
    output logic                            pps_o
);

    logic                         alt_pps;
    logic                         alt_led;
    logic [igp_pkg::EGPIO_W-1:0]  egpio_oe;
    logic [1:0]                   led_oe;
    logic [1:0]                   led_out;

    assign alt_pps = gpio_cfg_i.altf[igp_pkg::GPIO_FUNC_PPS];
    assign alt_led = gpio_cfg_i.altf[igp_pkg::GPIO_FUNC_LED];

    // Pin 2 becomes an input while PPS is routed
    always_comb begin
        egpio_oe = gpio_cfg_i.data_oe;
        if (alt_pps) begin
            egpio_oe[igp_pkg::GPIO_FUNC_PPS] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status LEDs, lit low: tx on 17, rx on 16
    assign led_oe  = alt_led ? 2'b11 : 2'b00;
    assign led_out = alt_led ? {~tx_active_i, ~rx_active_i} : 2'b00;

    assign user_gpio_oe_o  = {led_oe, 1'b0, egpio_oe};
    assign user_gpio_out_o = {led_out, 1'b0, gpio_cfg_i.data_out};

    assign pps_o = alt_pps && user_gpio_in_i[igp_pkg::GPIO_FUNC_PPS];

endmodule

`default_nettype wire

// File: rate_meter.sv
////////////////////////////////////////////////////////////////////////////
// Counts event pulses between rising reference edges
// First result after reset or a source change can be partial
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rate_meter (
    input  logic                      igp_clk,
    input  logic                      igp_rst,
    input  logic                      ref_i,
    input  logic                      event_i,
    output logic [igp_pkg::CNT_W-1:0] count_o,
    output logic                      count_valid_o
);

    logic                      ref_d;
    logic                      ref_rise;
    logic [igp_pkg::CNT_W-1:0] cnt;

    assign ref_rise = ref_i && !ref_d;

    always_ff @(posedge igp_clk) begin
        if (igp_rst) begin
            ref_d         <= 1'b0;
            cnt           <= '0;
            count_valid_o <= 1'b0;
        end else begin
            ref_d         <= ref_i;
            count_valid_o <= ref_rise;
            // An event in the edge cycle opens the new period
            if (ref_rise) begin
                cnt <= igp_pkg::CNT_W'(event_i);
            end else if (event_i) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Result register
    always_ff @(posedge igp_clk) begin
        if (ref_rise) begin
            count_o <= cnt;
        end
    end

    // Reference too slow for the counter width
    a_cnt_no_wrap: assert property (@(posedge igp_clk) disable iff (igp_rst)
        !(&cnt));

endmodule

`default_nettype wire

// File: ref_tick_gen.sv
////////////////////////////////////////////////////////////////////////////
// Reference level source: external PPS, internal divider or off
// Output is registered, so it lags its source by one cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ref_tick_gen (
    input  logic              igp_clk,
    input  logic              igp_rst,
    input  igp_pkg::ref_sel_e ref_sel_i,
    input  logic              pps_i,
    output logic              ref_o
);

    logic [igp_pkg::REF_DIV_W-1:0] div_cnt;
    logic                          int_level;

    ////////////////////////////////////////////////////////////////////////////
    // Internal half-period divider
    always_ff @(posedge igp_clk) begin
        if (igp_rst) begin
            div_cnt   <= '0;
            int_level <= 1'b0;
        end else if (div_cnt == igp_pkg::REF_DIV_W'(igp_pkg::REF_HALF_PERIOD - 1)) begin
            div_cnt   <= '0;
            int_level <= ~int_level;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Source select
    always_ff @(posedge igp_clk) begin
        if (igp_rst) begin
            ref_o <= 1'b0;
        end else begin
            case (ref_sel_i)
                igp_pkg::REF_PPS:      ref_o <= pps_i;
                igp_pkg::REF_INTERNAL: ref_o <= int_level;
                igp_pkg::REF_OFF:      ref_o <= 1'b0;
                // Unnamed code 3 also off
                default:               ref_o <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb_app_top.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for app_top; inputs change on the falling edge, outputs are
// checked there too. Stops at the first mismatch or timeout
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_app_top;

    localparam int RESET_TIMEOUT = 20;
    localparam int SETTLE_CYCLES = 4;

    // One register write and the outputs expected one cycle later
    typedef struct packed {
        logic [igp_pkg::GPO_ADDR_W-1:0]  addr;
        logic [7:0]                      data;
        logic [6:0]                      ctrl;
        logic [igp_pkg::USER_GPIO_W-1:0] gpio_out;
        logic [igp_pkg::USER_GPIO_W-1:0] gpio_oe;
    } vec_t;

    logic                            igp_clk;
    logic                            igp_rst;
    igp_pkg::gpo_wr_t                gpo_wr_i;
    logic [igp_pkg::ADC_W-1:0]       rxd_data_i;
    logic                            rxd_iqsel_i;
    logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_in_i;
    igp_pkg::board_ctrl_t            board_ctrl_o;
    igp_pkg::iq_sample_t             sample_o;
    logic                            sample_valid_o;
    logic [igp_pkg::CNT_W-1:0]       meas_count_o;
    logic                            meas_valid_o;
    logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_out_o;
    logic [igp_pkg::USER_GPIO_W-1:0] user_gpio_oe_o;

    integer seed;
    vec_t   vectors[$];

    tb_clk_gen clk_gen_i (
        .clk_o (igp_clk),
        .rst_o (igp_rst)
    );

    app_top dut_i (
        .igp_clk         (igp_clk),
        .igp_rst         (igp_rst),
        .gpo_wr_i        (gpo_wr_i),
        .rxd_data_i      (rxd_data_i),
        .rxd_iqsel_i     (rxd_iqsel_i),
        .user_gpio_in_i  (user_gpio_in_i),
        .board_ctrl_o    (board_ctrl_o),
        .sample_o        (sample_o),
        .sample_valid_o  (sample_valid_o),
        .meas_count_o    (meas_count_o),
        .meas_valid_o    (meas_valid_o),
        .user_gpio_out_o (user_gpio_out_o),
        .user_gpio_oe_o  (user_gpio_oe_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure handling and checks
    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Strobe lasts one cycle; returns on the falling edge after it
    task automatic write_reg(input logic [igp_pkg::GPO_ADDR_W-1:0] addr,
                             input logic [7:0] data);
        gpo_wr_i.valid = 1'b1;
        gpo_wr_i.addr  = addr;
        gpo_wr_i.data  = data;
        @(negedge igp_clk);
        gpo_wr_i = '0;
    endtask

    task automatic add_vec(input igp_pkg::gpo_reg_e addr, input logic [7:0] data,
                           input logic [6:0] ctrl, input logic [17:0] gpio_out,
                           input logic [17:0] gpio_oe);
        vec_t v;
        v.addr     = addr;
        v.data     = data;
        v.ctrl     = ctrl;
        v.gpio_out = gpio_out;
        v.gpio_oe  = gpio_oe;
        vectors.push_back(v);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus loops
    // Feeds q then i; a valid must follow each i half when enabled
    task automatic run_pairs(input int pairs, input bit en);
        int          rnd;
        bit          exp_valid;
        logic [11:0] model_i;
        logic [11:0] model_q;
        exp_valid = 1'b0;
        model_i   = '0;
        model_q   = '0;
        for (int k = 0; k <= 2 * pairs; k++) begin
            check_eq("sample_valid_o", 32'(sample_valid_o), 32'(exp_valid));
            if (exp_valid) begin
                check_eq("sample_o", 32'(sample_o), {8'h00, model_i, model_q});
            end
            if (k == 2 * pairs) begin
                rxd_iqsel_i = 1'b0;
            end else begin
                rnd         = $random(seed);
                rxd_iqsel_i = k[0];
                rxd_data_i  = rnd[11:0];
                if (k[0]) begin
                    model_i = rnd[11:0];
                end else begin
                    model_q = rnd[11:0];
                end
                exp_valid = en && k[0];
                @(negedge igp_clk);
            end
        end
    endtask

    // Continuous streaming; the first result and early ones are partial
    task automatic run_meter(input int checks, input int exp_count,
                             input int pps_half, input int max_cycles);
        int rnd;
        int seen;
        int cyc;
        bit pps_level;
        seen      = 0;
        cyc       = 0;
        pps_level = 1'b0;
        while (seen <= checks && cyc < max_cycles) begin
            if (meas_valid_o && cyc >= SETTLE_CYCLES) begin
                if (seen > 0) begin
                    check_eq("meas_count_o", 32'(meas_count_o), 32'(exp_count));
                end
                seen++;
            end
            if (pps_half > 0) begin
                check_eq("user_gpio_oe_o[2]", 32'(user_gpio_oe_o[2]), 32'd0);
                if (cyc > 0 && cyc % pps_half == 0) begin
                    pps_level = ~pps_level;
                end
                user_gpio_in_i[igp_pkg::GPIO_FUNC_PPS] = pps_level;
            end
            rnd         = $random(seed);
            rxd_iqsel_i = cyc[0];
            rxd_data_i  = rnd[11:0];
            cyc++;
            @(negedge igp_clk);
        end
        rxd_iqsel_i    = 1'b0;
        user_gpio_in_i = '0;
        if (seen <= checks) begin
            $display("Timeout: rate meter gave %0d of %0d results in %0d cycles",
                     seen, checks + 1, max_cycles);
            stop_run();
        end
    endtask

    // PPS stays routed, so pin 2 keeps toggling while the reference is off
    task automatic check_no_meas(input int cycles, input int pps_half);
        int rnd;
        bit pps_level;
        pps_level = 1'b0;
        for (int cyc = 0; cyc < cycles; cyc++) begin
            check_eq("meas_valid_o", 32'(meas_valid_o), 32'd0);
            if (cyc > 0 && cyc % pps_half == 0) begin
                pps_level = ~pps_level;
            end
            user_gpio_in_i[igp_pkg::GPIO_FUNC_PPS] = pps_level;
            rnd         = $random(seed);
            rxd_iqsel_i = cyc[0];
            rxd_data_i  = rnd[11:0];
            @(negedge igp_clk);
        end
        rxd_iqsel_i    = 1'b0;
        user_gpio_in_i = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int wait_cyc;
        seed           = 26686;
        gpo_wr_i       = '0;
        rxd_data_i     = '0;
        rxd_iqsel_i    = 1'b0;
        user_gpio_in_i = '0;

        // ctrl bits: lms_rst_n rxmix_en txsw rxsw dcen led enable_osc
        add_vec(igp_pkg::LMS_RST,     8'h01, 7'b1000000, 18'h00000, 18'h00000);
        add_vec(igp_pkg::RXMIX_EN,    8'hFF, 7'b1100000, 18'h00000, 18'h00000);
        add_vec(igp_pkg::TXSW,        8'h03, 7'b1110000, 18'h00000, 18'h00000);
        add_vec(igp_pkg::RXSW,        8'h01, 7'b1111000, 18'h00000, 18'h00000);
        add_vec(igp_pkg::BOOSTER,     8'h81, 7'b1111100, 18'h00000, 18'h00000);
        add_vec(igp_pkg::LED,         8'h01, 7'b1111110, 18'h00000, 18'h00000);
        add_vec(igp_pkg::ENABLE_OSC,  8'h01, 7'b1111111, 18'h00000, 18'h00000);
        add_vec(igp_pkg::TXSW,        8'h02, 7'b1101111, 18'h00000, 18'h00000);
        add_vec(igp_pkg::LMS_RST,     8'h00, 7'b0101111, 18'h00000, 18'h00000);
        // GPIO bytes, then LED and PPS alternate functions
        add_vec(igp_pkg::GPIO_OUT_LO, 8'hA5, 7'b0101111, 18'h000A5, 18'h00000);
        add_vec(igp_pkg::GPIO_OUT_HI, 8'hD3, 7'b0101111, 18'h053A5, 18'h00000);
        add_vec(igp_pkg::GPIO_OE_LO,  8'h3C, 7'b0101111, 18'h053A5, 18'h0003C);
        add_vec(igp_pkg::GPIO_OE_HI,  8'hFF, 7'b0101111, 18'h053A5, 18'h07F3C);
        add_vec(igp_pkg::GPIO_ALTF,   8'h01, 7'b0101111, 18'h153A5, 18'h37F3C);
        add_vec(igp_pkg::LED,         8'h00, 7'b0101101, 18'h353A5, 18'h37F3C);
        add_vec(igp_pkg::STREAM,      8'h01, 7'b0101101, 18'h253A5, 18'h37F3C);
        add_vec(igp_pkg::GPIO_ALTF,   8'h05, 7'b0101101, 18'h253A5, 18'h37F38);
        add_vec(igp_pkg::GPIO_ALTF,   8'h00, 7'b0101101, 18'h053A5, 18'h07F3C);
        add_vec(igp_pkg::STREAM,      8'h00, 7'b0101101, 18'h053A5, 18'h07F3C);

        wait_cyc = 0;
        @(negedge igp_clk);
        while (igp_rst && wait_cyc < RESET_TIMEOUT) begin
            @(negedge igp_clk);
            wait_cyc++;
        end
        if (igp_rst) begin
            $display("Timeout: reset still active after %0d cycles", RESET_TIMEOUT);
            stop_run();
        end

        check_eq("board_ctrl_o", 32'(board_ctrl_o), 32'd0);
        check_eq("sample_valid_o", 32'(sample_valid_o), 32'd0);
        check_eq("meas_valid_o", 32'(meas_valid_o), 32'd0);
        check_eq("user_gpio_oe_o", 32'(user_gpio_oe_o), 32'd0);

        foreach (vectors[n]) begin
            write_reg(vectors[n].addr, vectors[n].data);
            check_eq("board_ctrl_o", 32'(board_ctrl_o), 32'(vectors[n].ctrl));
            check_eq("user_gpio_out_o", 32'(user_gpio_out_o), 32'(vectors[n].gpio_out));
            check_eq("user_gpio_oe_o", 32'(user_gpio_oe_o), 32'(vectors[n].gpio_oe));
        end

        // IQ pairing on and off
        write_reg(igp_pkg::STREAM, 8'h01);
        run_pairs(24, 1'b1);
        write_reg(igp_pkg::STREAM, 8'h00);
        run_pairs(8, 1'b0);

        // Internal reference, 100 cycles per period
        write_reg(igp_pkg::STREAM, 8'h01);
        write_reg(igp_pkg::CLKMEAS, 8'(igp_pkg::REF_INTERNAL));
        run_meter(2, 50, 0, 500);

        // External PPS on pin 2, 200 cycles per period
        write_reg(igp_pkg::GPIO_ALTF, 8'h04);
        write_reg(igp_pkg::CLKMEAS, 8'(igp_pkg::REF_PPS));
        run_meter(2, 100, 100, 800);
        write_reg(igp_pkg::CLKMEAS, 8'(igp_pkg::REF_OFF));
        check_no_meas(400, 100);
        write_reg(igp_pkg::GPIO_ALTF, 8'h00);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset: 40 ns period, reset high for 5 cycles
// Reset drops right after the fifth rising edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire
